// File: common/loader_pkg.sv
`default_nettype none

package loader_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////////////

    // widest word address any memory build may use
    localparam int MAX_ADDR_W = 10;

    // sync word, sent on the wire as ef be ad de
    localparam logic [31:0] LOAD_MARKER = 32'hdeadbeef;

    ////////////////////////////////////////////////////////////////////////////
    // byte stream and memory write port
    ////////////////////////////////////////////////////////////////////////////

    // one received byte
    // valid is a strobe on the receiver side, not-empty on the fifo side
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    // loader to memory
    // address sized for the largest build, upper bits unused when smaller
    typedef struct packed {
        logic                  we;
        logic [MAX_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } mem_wr_t;

    ////////////////////////////////////////////////////////////////////////////
    // loader fsm
    ////////////////////////////////////////////////////////////////////////////

    // seek  hunting for the first marker
    // load  packing words into memory
    // done  load finished, hunting for the next marker
    typedef enum logic [1:0] {
        st_seek = 2'd0,
        st_load = 2'd1,
        st_done = 2'd2
    } load_state_e;

endpackage

`default_nettype wire

// File: uart/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 rx,
    output loader_pkg::rx_byte_t byte_out,
    output logic                 frame_err
);

    typedef enum logic [1:0] {
        rx_idle  = 2'd0,
        rx_start = 2'd1,
        rx_data  = 2'd2,
        rx_stop  = 2'd3
    } rx_state_e;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    // start bit is checked half a bit in, every later bit one full bit on
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             byte_valid;
    logic             bit_tick;

    ////////////////////////////////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////////////////////////////////

    // two flops for metastability, third one for falling-edge detect
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign bit_tick = (clk_cnt == FULL_BIT);

    ////////////////////////////////////////////////////////////////////////////
    // frame fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= rx_idle;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end
        else
        begin
            // both reports are single-cycle strobes
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            case (state)
                rx_idle:
                begin
                    clk_cnt <= '0;
                    // needs a real high-to-low edge, a stuck-low line is ignored
                    if (rx_prev && !rx_sync)
                        state <= rx_start;
                end
                rx_start:
                begin
                    if (clk_cnt == HALF_BIT)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        // high again at mid-bit means a glitch, drop it
                        state   <= rx_sync ? rx_idle : rx_data;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                rx_data:
                begin
                    if (bit_tick)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= rx_stop;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                rx_stop:
                begin
                    if (bit_tick)
                    begin
                        clk_cnt    <= '0;
                        state      <= rx_idle;
                        // stop bit decides: byte or framing error
                        byte_valid <= rx_sync;
                        frame_err  <= !rx_sync;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                default:
                    state <= rx_idle;
            endcase
        end
    end

    // lsb first on the wire
    always_ff @(posedge clk)
    begin
        if (state == rx_data && bit_tick)
            shift_reg <= {rx_sync, shift_reg[7:1]};
    end

    assign byte_out.valid = byte_valid;
    assign byte_out.data  = shift_reg;

    // one verdict per frame, never both
    assert property (@(posedge clk) disable iff (!arst_n)
        !(byte_out.valid && frame_err));

endmodule

`default_nettype wire

// File: uart/rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  loader_pkg::rx_byte_t push,
    output loader_pkg::rx_byte_t head,
    input  logic                 pop,
    output logic                 overrun
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(FIFO_DEPTH);

    logic [7:0]       fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == FULL);
    assign empty   = (count == '0);
    // full means dropped, even with a pop on the same edge
    assign do_push = push.valid && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
            fifo_mem[wr_ptr] <= push.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers, occupancy, overrun
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            // explicit wrap, depth need not be a power of two
            if (do_push)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (push.valid && full)
                overrun <= 1'b1;
        end
    end

    assign head.valid = !empty;
    assign head.data  = fifo_mem[rd_ptr];

    // consumer must only pop what it was shown
    assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

`default_nettype wire

// File: hdl/word_loader.sv
`timescale 1ns/1ps
`default_nettype none

module word_loader #(
    parameter int ADDR_W = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  loader_pkg::rx_byte_t byte_in,
    output logic                 pop,
    output loader_pkg::mem_wr_t  wr,
    output logic                 loading,
    output logic                 load_done,
    output logic [ADDR_W:0]      word_count
);

    import loader_pkg::*;

    load_state_e           state;
    logic [31:0]           window;
    logic [31:0]           next_window;
    logic [1:0]            byte_cnt;
    logic                  marker_hit;
    logic                  word_end;
    logic                  wr_we;
    logic [MAX_ADDR_W-1:0] wr_addr;
    logic [31:0]           wr_data;
    logic                  done_pulse;

    if (ADDR_W > MAX_ADDR_W)
    begin : g_addr_check
        $error("word_loader: ADDR_W exceeds MAX_ADDR_W");
    end

    // never holds the fifo, every byte is consumed as it shows up
    assign pop = byte_in.valid;

    // new byte enters at the top, so after four bytes the first is [7:0]
    assign next_window = {byte_in.data, window[31:8]};
    assign marker_hit  = (next_window == LOAD_MARKER);
    assign word_end    = pop && (state == st_load) && (byte_cnt == 2'd3);

    ////////////////////////////////////////////////////////////////////////////
    // control fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= st_seek;
            window     <= '0;
            byte_cnt   <= '0;
            word_count <= '0;
            wr_we      <= 1'b0;
            done_pulse <= 1'b0;
        end
        else
        begin
            wr_we      <= 1'b0;
            done_pulse <= 1'b0;
            if (pop)
            begin
                window <= next_window;
                case (state)
                    // sliding match at any byte alignment
                    st_seek, st_done:
                    begin
                        if (marker_hit)
                        begin
                            state      <= st_load;
                            byte_cnt   <= '0;
                            word_count <= '0;
                        end
                    end
                    st_load:
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                        begin
                            if (marker_hit)
                            begin
                                // closing marker is not stored
                                state      <= st_done;
                                done_pulse <= 1'b1;
                            end
                            else
                            begin
                                // past the end of memory: counted, not written
                                wr_we <= !word_count[ADDR_W];
                                if (!(&word_count))
                                    word_count <= word_count + 1'b1;
                            end
                        end
                    end
                    default:
                        state <= st_seek;
                endcase
            end
        end
    end

    // write payload, captured with the fourth byte
    always_ff @(posedge clk)
    begin
        if (word_end)
        begin
            wr_addr <= MAX_ADDR_W'(word_count[ADDR_W-1:0]);
            wr_data <= next_window;
        end
    end

    assign wr.we   = wr_we;
    assign wr.addr = wr_addr;
    assign wr.data = wr_data;

    assign loading   = (state == st_load);
    assign load_done = done_pulse;

    // a write always follows a pop and lands while still loading
    assert property (@(posedge clk) disable iff (!arst_n)
        wr.we |-> (state == st_load) && $past(pop));

endmodule

`default_nettype wire

// File: hdl/prog_mem.sv
`timescale 1ns/1ps
`default_nettype none

module prog_mem #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  loader_pkg::mem_wr_t wr,
    input  logic                busy,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [ADDR_W+1:0]   paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [31:0]       mem [DEPTH];
    logic              setup;
    logic [ADDR_W-1:0] rd_addr;
    logic              refused;

    ////////////////////////////////////////////////////////////////////////////
    // loader write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr.we)
            mem[wr.addr[ADDR_W-1:0]] <= wr.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // apb read slave
    ////////////////////////////////////////////////////////////////////////////

    assign setup   = psel && !penable;
    // byte address in, word address out
    assign rd_addr = paddr[ADDR_W+1:2];
    // read-only port
    // pwdata arrives with a write but a write is always refused
    assign refused = pwrite || (paddr[1:0] != 2'b00) || busy;

    // zero wait states, response ready in the first access cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
        else
        begin
            pready  <= setup;
            pslverr <= setup && refused;
        end
    end

    always_ff @(posedge clk)
    begin
        if (setup)
            prdata <= refused ? '0 : mem[rd_addr];
    end

    // pready only ever answers an access phase
    assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> psel && penable);

endmodule

`default_nettype wire

// File: hdl/loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module loader_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 8,
    parameter int ADDR_W       = 8
) (
    input  logic              clk,
    input  logic              arst_n,
    // serial line, idle high
    input  logic              rx,
    // apb readback
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W+1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    // status
    output logic              loading,
    output logic              load_done,
    output logic [ADDR_W:0]   word_count,
    output logic              frame_err,
    output logic              rx_overrun
);

    import loader_pkg::*;

    rx_byte_t rx_byte;
    rx_byte_t fifo_head;
    logic     fifo_pop;
    mem_wr_t  mem_wr;

    ////////////////////////////////////////////////////////////////////////////
    // rx -> fifo -> loader -> memory
    ////////////////////////////////////////////////////////////////////////////

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_rx_u (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .byte_out (rx_byte),
        .frame_err(frame_err)
    );

    rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_fifo_u (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (rx_byte),
        .head   (fifo_head),
        .pop    (fifo_pop),
        .overrun(rx_overrun)
    );

    word_loader #(
        .ADDR_W(ADDR_W)
    ) word_loader_u (
        .clk       (clk),
        .arst_n    (arst_n),
        .byte_in   (fifo_head),
        .pop       (fifo_pop),
        .wr        (mem_wr),
        .loading   (loading),
        .load_done (load_done),
        .word_count(word_count)
    );

    // apb reads are refused while a load is running
    prog_mem #(
        .ADDR_W(ADDR_W)
    ) prog_mem_u (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (mem_wr),
        .busy   (loading),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5
) (
    output logic clk
);

    // free-running, low at time zero
    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tests/tb_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_loader;

    import loader_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 8;
    localparam int ADDR_W       = 8;
    localparam int DEPTH        = 2 ** ADDR_W;
    // a few frames worth of cycles
    localparam int WAIT_LIMIT   = 50 * CLKS_PER_BIT;
    localparam int FIRST_WORDS  = 20;
    localparam int SECOND_WORDS = 5;

    logic              clk;
    logic              arst_n;
    logic              rx;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W+1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              loading;
    logic              load_done;
    logic [ADDR_W:0]   word_count;
    logic              frame_err;
    logic              rx_overrun;

    // every byte put on the wire, bit 8 set for a good stop bit
    logic [8:0]  sent [0:255];
    int          sent_len;
    logic [31:0] exp_mem [DEPTH];
    int          exp_count;
    load_state_e model_state;
    integer      seed;
    int          done_count;
    int          frame_err_count;

    tb_clock_gen #(
        .HALF_PERIOD_NS(5)
    ) tb_clock_gen_u (
        .clk(clk)
    );

    loader_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .ADDR_W      (ADDR_W)
    ) loader_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .loading   (loading),
        .load_done (load_done),
        .word_count(word_count),
        .frame_err (frame_err),
        .rx_overrun(rx_overrun)
    );

    // counters for the one-cycle status strobes
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done_count      <= 0;
            frame_err_count <= 0;
        end
        else
        begin
            if (load_done)
                done_count <= done_count + 1;
            if (frame_err)
                frame_err_count <= frame_err_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // replays everything sent since reset, returns the last load's word count
    function automatic int build_expected(input int len);
        load_state_e st;
        logic [31:0] win;
        int          nbytes;
        int          cnt;
        st     = st_seek;
        win    = '0;
        nbytes = 0;
        cnt    = 0;
        for (int i = 0; i < DEPTH; i++)
            exp_mem[i] = 'x;
        for (int i = 0; i < len; i++)
        begin
            // bad stop bit, byte never reaches the loader
            if (sent[i][8])
            begin
                // first byte of four ends up in the low lane
                win = {sent[i][7:0], win[31:8]};
                if (st == st_load)
                begin
                    nbytes++;
                    if (nbytes == 4)
                    begin
                        nbytes = 0;
                        if (win == LOAD_MARKER)
                            st = st_done;
                        else
                        begin
                            if (cnt < DEPTH)
                                exp_mem[cnt] = win;
                            cnt++;
                        end
                    end
                end
                else if (win == LOAD_MARKER)
                begin
                    // new load restarts at address zero
                    st     = st_load;
                    nbytes = 0;
                    cnt    = 0;
                end
            end
        end
        model_state = st;
        return cnt;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s never came", what);
        $display("test failed");
        $fatal(1, "wait timed out");
    endtask

    // one bit time on the line
    task automatic hold_bit(input logic level);
        @(posedge clk);
        rx <= level;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // start, data lsb first, stop, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_ok);
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++)
            hold_bit(data[i]);
        hold_bit(stop_ok);
        hold_bit(1'b1);
        sent[sent_len] = {stop_ok, data};
        sent_len++;
    endtask

    // little-endian on the wire
    task automatic send_word(input logic [31:0] word);
        for (int i = 0; i < 4; i++)
            send_frame(word[8*i +: 8], 1'b1);
    endtask

    task automatic wait_loading();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!loading && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!loading)
            report_timeout("rise of loading");
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (done_count < target && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (done_count < target)
            report_timeout("load_done pulse");
    endtask

    // setup, access, then wait for pready sampled mid-cycle
    task automatic apb_access(input logic write, input int word_addr,
                              output logic [31:0] rdata, output logic err);
        int                cycles;
        logic [ADDR_W+1:0] byte_addr;
        byte_addr = word_addr * 4;
        cycles    = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= byte_addr;
        pwdata  <= write ? 32'h1234_5678 : 32'h0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!pready)
            report_timeout("apb pready");
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic compare_image(input string name, input int nwords);
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < nwords; i++)
        begin
            apb_access(1'b0, i, rdata, err);
            check_value($sformatf("%s_err[%0d]", name, i), 32'd0, {31'b0, err});
            check_value($sformatf("%s[%0d]", name, i), exp_mem[i], rdata);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin : main
        logic [31:0] word;
        logic [31:0] rdata;
        logic        err;
        int          target;
        int          errs_before;
        seed     = 32'hf37d7ef4;
        sent_len = 0;
        rx       = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        arst_n   = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_loading", 32'd0, {31'b0, loading});
        check_value("reset_load_done", 32'd0, {31'b0, load_done});
        check_value("reset_frame_err", 32'd0, {31'b0, frame_err});
        check_value("reset_overrun", 32'd0, {31'b0, rx_overrun});
        check_value("reset_pready", 32'd0, {31'b0, pready});
        check_value("reset_word_count", 32'd0, word_count);

        // garbage with partial markers, no window matches until the final de
        send_frame(8'h11, 1'b1);
        send_frame(8'hef, 1'b1);
        send_frame(8'hbe, 1'b1);
        send_frame(8'had, 1'b1);
        send_frame(8'h22, 1'b1);
        send_frame(8'hef, 1'b1);
        send_frame(8'hbe, 1'b1);
        send_frame(8'had, 1'b1);
        @(negedge clk);
        check_value("garbage_loading", 32'd0, {31'b0, loading});
        send_frame(8'hde, 1'b1);
        wait_loading();

        // memory locked while a load runs
        apb_access(1'b0, 0, rdata, err);
        check_value("busy_read_err", 32'd1, {31'b0, err});
        check_value("busy_read_data", 32'd0, rdata);

        for (int i = 0; i < FIRST_WORDS; i++)
        begin
            word = $random(seed);
            // a data word equal to the marker would close the load
            while (word == LOAD_MARKER)
                word = $random(seed);
            send_word(word);
        end
        @(negedge clk);
        target = done_count + 1;
        send_word(LOAD_MARKER);
        wait_done(target);

        exp_count = build_expected(sent_len);
        $display("first load finished, model state %s", model_state.name());
        check_value("first_model_count", FIRST_WORDS, exp_count);
        check_value("first_word_count", exp_count, word_count);
        check_value("first_loading", 32'd0, {31'b0, loading});
        compare_image("first_load", FIRST_WORDS);

        // writes refused, memory untouched
        apb_access(1'b1, 3, rdata, err);
        check_value("write_err", 32'd1, {31'b0, err});
        check_value("write_data", 32'd0, rdata);
        apb_access(1'b0, 3, rdata, err);
        check_value("after_write_err", 32'd0, {31'b0, err});
        check_value("after_write_data", exp_mem[3], rdata);

        // second load, one bad frame in the middle
        @(negedge clk);
        errs_before = frame_err_count;
        send_word(LOAD_MARKER);
        wait_loading();
        for (int i = 0; i < SECOND_WORDS; i++)
        begin
            word = $random(seed);
            while (word == LOAD_MARKER)
                word = $random(seed);
            send_word(word);
            if (i == 2)
                send_frame(8'h5a, 1'b0);
        end
        @(negedge clk);
        target = done_count + 1;
        send_word(LOAD_MARKER);
        wait_done(target);

        check_value("frame_err_pulses", errs_before + 1, frame_err_count);
        exp_count = build_expected(sent_len);
        $display("second load finished, model state %s", model_state.name());
        check_value("second_model_count", SECOND_WORDS, exp_count);
        check_value("second_word_count", exp_count, word_count);
        // words 5..19 still from the first load
        compare_image("second_load", FIRST_WORDS);
        check_value("final_overrun", 32'd0, {31'b0, rx_overrun});

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/loader_pkg.sv
uart/uart_rx.sv
uart/rx_fifo.sv
hdl/word_loader.sv
hdl/prog_mem.sv
hdl/loader_top.sv
tests/tb_clock_gen.sv
tests/tb_loader.sv
